/* Makefile */
# Verilator flow for the revo trigger encoder

VERILATOR ?= verilator
FILE_LIST ?= sources.f
TB_TOP ?= revo_trigger_tb
RTL_TOP ?= revo_trigger_top
OBJ_DIR ?= obj_dir
JOBS ?= 0
TIMESCALE ?= --timescale 1ns/100ps
LINT_FLAGS ?= -Wall
SIM_FLAGS ?= -Wno-fatal
PASS_TEXT ?= ALL TESTS PASSED

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
RTL_SRCS := $(filter logic/%,$(SOURCES))
SIM_BIN := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

# design only, the testbench is not linted
lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(TIMESCALE) \
		--top-module $(RTL_TOP) $(RTL_SRCS)

$(SIM_BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) --binary --timing $(TIMESCALE) -j $(JOBS) \
		--top-module $(TB_TOP) --Mdir $(OBJ_DIR) $(SIM_FLAGS) \
		-f $(FILE_LIST)

# status comes from the pass text in the run output
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* logic/frame_word_encoder.sv */
`default_nettype none

module frame_word_encoder (
	input wire clock2,
	input wire reset,
	input wire trg_valid,
	output logic trg_ready,
	output logic word_valid,
	output revo_pkg::revo_word_t word,
	input wire word_ready,
	output revo_pkg::trg_count_t trg_count
);

	logic trg_taken;

	// ------------------------------------------------------------
	// word offer
	// ------------------------------------------------------------

	// a null word is always there to send, so valid simply comes up
	// one clock after reset and stays
	always_ff @(posedge clock2) begin
		if (reset) begin
			word_valid <= 1'b0;
		end else begin
			word_valid <= 1'b1;
		end
	end

	// trigger is consumed in the same slot the serializer takes the word
	assign trg_ready = word_valid && word_ready;
	assign trg_taken = trg_valid && trg_ready;

	// word only changes in the accepting cycle
	// outside of it the null pattern sits there steady
	always_comb begin
		if (trg_taken) begin
			word = revo_pkg::WORD_TRG;
		end else begin
			word = revo_pkg::WORD_NULL;
		end
	end

	// ------------------------------------------------------------
	// sent trigger count
	// ------------------------------------------------------------

	// wraps at the top since the receiver only looks at differences
	always_ff @(posedge clock2) begin
		if (reset) begin
			trg_count <= '0;
		end else if (trg_taken) begin
			trg_count <= trg_count + revo_pkg::trg_count_t'(1);
		end
	end

endmodule

`default_nettype wire

/* logic/revo_pkg.sv */
`default_nettype none

package revo_pkg;

	// ------------------------------------------------------------
	// frame words
	// ------------------------------------------------------------

	// one frame on the serial line, sent msb first
	typedef logic [7:0] revo_word_t;

	// idle frame, sent whenever no trigger is pending
	localparam revo_word_t WORD_NULL = 8'b11000000;

	// trigger frame, the inverse pattern of the idle frame
	localparam revo_word_t WORD_TRG = 8'b00111111;

	// ------------------------------------------------------------
	// qualification and counting
	// ------------------------------------------------------------

	// longest revo pulse still taken as a trigger, in samples
	localparam int DEFAULT_MAX_WIDTH = 8;

	// number of trigger words sent, wraps at the top
	typedef logic [15:0] trg_count_t;

endpackage

`default_nettype wire

/* logic/revo_pulse_qualifier.sv */
`default_nettype none

module revo_pulse_qualifier #(
	parameter int MAX_WIDTH = revo_pkg::DEFAULT_MAX_WIDTH,
	parameter int SYNC_STAGES = 2
) (
	input wire clock2,
	input wire reset,
	input wire revo_in,
	output logic trg_valid,
	input wire trg_ready
);

	// run counter has to hold MAX_WIDTH+1 as the first overlong value
	localparam int COUNT_BITS = $clog2(MAX_WIDTH + 2);
	localparam logic [COUNT_BITS-1:0] COUNT_MAX = COUNT_BITS'(MAX_WIDTH);
	localparam logic [COUNT_BITS-1:0] COUNT_SAT = COUNT_BITS'(MAX_WIDTH + 1);

	logic [SYNC_STAGES-1:0] sync_q;
	logic revo_sync;
	logic [COUNT_BITS-1:0] run_count;
	logic run_end;
	logic pulse_ok;

	// ------------------------------------------------------------
	// synchronizer chain
	// ------------------------------------------------------------

	// plain flop chain since revo_in has no relation to clock2
	always_ff @(posedge clock2) begin
		if (reset) begin
			sync_q <= '0;
		end else begin
			sync_q[0] <= revo_in;
			for (int i = 1; i < SYNC_STAGES; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
		end
	end

	assign revo_sync = sync_q[SYNC_STAGES-1];

	// ------------------------------------------------------------
	// pulse width measurement
	// ------------------------------------------------------------

	// counts high samples of the current run
	// stops at COUNT_SAT so a stuck line never wraps back into range
	always_ff @(posedge clock2) begin
		if (reset) begin
			run_count <= '0;
		end else if (revo_sync) begin
			if (run_count != COUNT_SAT) begin
				run_count <= run_count + COUNT_BITS'(1);
			end
		end else begin
			run_count <= '0;
		end
	end

	// first low sample after a high run while the count still holds the width
	assign run_end = !revo_sync && (run_count != '0);

	// width 1 up to MAX_WIDTH is a trigger
	// anything that reached COUNT_SAT is a stuck or overlong line
	assign pulse_ok = run_end && (run_count <= COUNT_MAX);

	// ------------------------------------------------------------
	// pending trigger
	// ------------------------------------------------------------

	// held until the encoder takes it
	// a second good pulse before that just merges in
	// a transfer in the same cycle as a new pulse keeps the flag up
	always_ff @(posedge clock2) begin
		if (reset) begin
			trg_valid <= 1'b0;
		end else begin
			trg_valid <= pulse_ok || (trg_valid && !trg_ready);
		end
	end

endmodule

`default_nettype wire

/* logic/revo_trigger_top.sv */
`default_nettype none

module revo_trigger_top #(
	parameter int MAX_WIDTH = revo_pkg::DEFAULT_MAX_WIDTH,
	parameter int SYNC_STAGES = 2
) (
	input wire clock2,
	input wire reset,
	input wire revo_in,
	output logic serial_data,
	output logic serial_frame,
	output logic trg_active,
	output revo_pkg::trg_count_t trg_count
);

	// qualifier to encoder
	logic trg_valid;
	logic trg_ready;

	// encoder to serializer
	logic word_valid;
	logic word_ready;
	revo_pkg::revo_word_t word;

	// ------------------------------------------------------------
	// pulse qualification, encoding, serialization
	// ------------------------------------------------------------

	revo_pulse_qualifier #(
		.MAX_WIDTH(MAX_WIDTH),
		.SYNC_STAGES(SYNC_STAGES)
	) qualifier (
		.clock2(clock2),
		.reset(reset),
		.revo_in(revo_in),
		.trg_valid(trg_valid),
		.trg_ready(trg_ready)
	);

	frame_word_encoder encoder (
		.clock2(clock2),
		.reset(reset),
		.trg_valid(trg_valid),
		.trg_ready(trg_ready),
		.word_valid(word_valid),
		.word(word),
		.word_ready(word_ready),
		.trg_count(trg_count)
	);

	word_serializer serializer (
		.clock2(clock2),
		.reset(reset),
		.word_valid(word_valid),
		.word(word),
		.word_ready(word_ready),
		.serial_data(serial_data),
		.serial_frame(serial_frame),
		.trg_active(trg_active)
	);

endmodule

`default_nettype wire

/* logic/word_serializer.sv */
`default_nettype none

module word_serializer (
	input wire clock2,
	input wire reset,
	input wire word_valid,
	input wire revo_pkg::revo_word_t word,
	output logic word_ready,
	output logic serial_data,
	output logic serial_frame,
	output logic trg_active
);

	localparam int WORD_BITS = $bits(revo_pkg::revo_word_t);
	localparam int INDEX_BITS = $clog2(WORD_BITS);
	localparam logic [INDEX_BITS-1:0] LAST_BIT = INDEX_BITS'(WORD_BITS - 1);

	revo_pkg::revo_word_t shift_q;
	logic [INDEX_BITS-1:0] bit_index;
	logic running;
	logic active_q;
	logic load;

	// ------------------------------------------------------------
	// handshake
	// ------------------------------------------------------------

	// ready on the last bit so the next word follows without a gap,
	// and while idle, which covers the cycle right after reset
	assign word_ready = !running || (bit_index == LAST_BIT);
	assign load = word_ready && word_valid;

	// ------------------------------------------------------------
	// shift register
	// ------------------------------------------------------------

	// frame word shifts out msb first
	always_ff @(posedge clock2) begin
		if (load) begin
			shift_q <= word;
		end else begin
			shift_q <= {shift_q[WORD_BITS-2:0], 1'b0};
		end
	end

	// bit position and frame state
	always_ff @(posedge clock2) begin
		if (reset) begin
			bit_index <= '0;
			running <= 1'b0;
			active_q <= 1'b0;
		end else if (load) begin
			bit_index <= '0;
			running <= 1'b1;
			active_q <= (word == revo_pkg::WORD_TRG);
		end else if (running) begin
			bit_index <= bit_index + INDEX_BITS'(1);
			// go idle when no word is offered at the end of a frame
			if (bit_index == LAST_BIT) begin
				running <= 1'b0;
				active_q <= 1'b0;
			end
		end
	end

	// ------------------------------------------------------------
	// line outputs
	// ------------------------------------------------------------

	// line carries the msb and stays low while idle
	assign serial_data = running && shift_q[WORD_BITS-1];
	assign serial_frame = running && (bit_index == '0);
	assign trg_active = active_q;

endmodule

`default_nettype wire

/* sources.f */
logic/revo_pkg.sv
logic/revo_pulse_qualifier.sv
logic/frame_word_encoder.sv
logic/word_serializer.sv
logic/revo_trigger_top.sv
test/clock_gen.sv
test/revo_trigger_tb.sv

/* test/clock_gen.sv */
`default_nettype none

module clock_gen #(
	parameter int PERIOD_NS = 20,
	parameter int RESET_CYCLES = 4
) (
	output logic clock2,
	output logic reset
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clock2 = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clock2 = ~clock2;
		end
	end

	// held over RESET_CYCLES rising edges, released on a falling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock2);
		@(negedge clock2);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

/* test/revo_trigger_tb.sv */
`default_nettype none

module revo_trigger_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_WIDTH = revo_pkg::DEFAULT_MAX_WIDTH;
	localparam int SYNC_STAGES = 2;
	localparam int RESET_CYCLES = 4;
	localparam int WORD_BITS = $bits(revo_pkg::revo_word_t);
	// latest frame start allowed after a pulse ends
	localparam int LATENCY_LIMIT = 2 * WORD_BITS + SYNC_STAGES + 1;
	localparam int GAP = 30;
	localparam int RANDOM_ENTRIES = 8;
	localparam int ALIGN_SLACK = 2 * WORD_BITS;
	localparam int TAIL_FRAMES = 50;

	logic clock2;
	logic reset;
	logic revo_in;
	logic serial_data;
	logic serial_frame;
	logic trg_active;
	revo_pkg::trg_count_t trg_count;

	// stimulus table with one pulse per entry
	int tab_width[$];
	int tab_gap[$];
	bit tab_merge[$];
	bit tab_align[$];
	int expected_total = 0;
	int table_cycles = 0;
	int limit_cycles = 0;
	bit table_ready = 1'b0;
	logic [31:0] lfsr_state = 32'h1443;

	// pulse ends still waiting for their trigger word
	int pending_end[$];

	int cycle = 0;
	int word_errors = 0;
	int count_errors = 0;
	int flag_errors = 0;
	int timing_errors = 0;

	// word recovery state
	bit in_frame = 1'b0;
	int bit_pos = 0;
	int frame_start = 0;
	int last_frame = -1;
	int frames_seen = 0;
	int trg_words = 0;
	revo_pkg::revo_word_t cur_word = '0;
	logic [WORD_BITS-1:0] active_bits = '0;

	clock_gen #(
		.PERIOD_NS(20),
		.RESET_CYCLES(RESET_CYCLES)
	) clocks (
		.clock2(clock2),
		.reset(reset)
	);

	revo_trigger_top #(
		.MAX_WIDTH(MAX_WIDTH),
		.SYNC_STAGES(SYNC_STAGES)
	) dut (
		.clock2(clock2),
		.reset(reset),
		.revo_in(revo_in),
		.serial_data(serial_data),
		.serial_frame(serial_frame),
		.trg_active(trg_active),
		.trg_count(trg_count)
	);

	always @(posedge clock2) begin
		cycle <= cycle + 1;
	end

	// ------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------

	task automatic check_word(input string name, input revo_pkg::revo_word_t got,
			input revo_pkg::revo_word_t exp);
		if (got !== exp) begin
			word_errors++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input revo_pkg::trg_count_t got,
			input revo_pkg::trg_count_t exp);
		if (got !== exp) begin
			count_errors++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			flag_errors++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// ------------------------------------------------------------
	// table building
	// ------------------------------------------------------------

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	function automatic int take_bits(input int count);
		int value;
		value = 0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = (value << 1) | int'(lfsr_state[0]);
		end
		return value;
	endfunction

	// a merging pulse shares its word with the next one, so it adds nothing
	task automatic add_entry(input int width, input int gap, input bit merge, input bit align);
		tab_width.push_back(width);
		tab_gap.push_back(gap);
		tab_merge.push_back(merge);
		tab_align.push_back(align);
		if (width >= 1 && width <= MAX_WIDTH && !merge) begin
			expected_total += 1;
		end
		table_cycles += width + gap + (align ? ALIGN_SLACK : 0);
	endtask

	task automatic build_table();
		add_entry(1, GAP, 1'b0, 1'b0);
		add_entry(2, GAP, 1'b0, 1'b0);
		add_entry(MAX_WIDTH, GAP, 1'b0, 1'b0);
		add_entry(MAX_WIDTH + 1, GAP, 1'b0, 1'b0);
		add_entry(20, GAP, 1'b0, 1'b0);
		// short pair whose ends both fall inside one pending window
		add_entry(1, 2, 1'b1, 1'b1);
		add_entry(1, GAP + 10, 1'b0, 1'b0);
		for (int i = 0; i < RANDOM_ENTRIES; i++) begin
			add_entry(take_bits(4) + 1, GAP, 1'b0, 1'b0);
		end
		limit_cycles = RESET_CYCLES + 4 * WORD_BITS + table_cycles + TAIL_FRAMES * WORD_BITS;
	endtask

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------

	// leaves the pulse judged in the first cycle of a frame
	// and well away from the next word_ready
	task automatic align_to_frame();
		while (!serial_frame) @(negedge clock2);
		repeat (WORD_BITS - SYNC_STAGES - 1) @(negedge clock2);
	endtask

	task automatic apply_entry(input int idx);
		if (tab_align[idx]) begin
			align_to_frame();
		end
		revo_in = 1'b1;
		repeat (tab_width[idx]) @(negedge clock2);
		revo_in = 1'b0;
		if (tab_width[idx] <= MAX_WIDTH && !tab_merge[idx]) begin
			pending_end.push_back(cycle);
		end
		repeat (tab_gap[idx]) @(negedge clock2);
	endtask

	// ------------------------------------------------------------
	// serial word recovery
	// ------------------------------------------------------------

	task automatic finish_word();
		int end_cycle;
		logic want_active;
		revo_pkg::trg_count_t seen;
		want_active = (cur_word == revo_pkg::WORD_TRG);
		if (frames_seen < 2) begin
			check_word("word after reset", cur_word, revo_pkg::WORD_NULL);
		end else if (!want_active) begin
			check_word("serial word", cur_word, revo_pkg::WORD_NULL);
		end
		if (want_active) begin
			trg_words++;
			if (pending_end.size() == 0) begin
				timing_errors++;
				$display("trigger word at cycle %0d with no qualified pulse waiting",
					frame_start);
			end else begin
				end_cycle = pending_end.pop_front();
				if (frame_start <= end_cycle) begin
					timing_errors++;
					$display("trigger word at cycle %0d came before its pulse ended at %0d",
						frame_start, end_cycle);
				end else if (frame_start > end_cycle + LATENCY_LIMIT) begin
					timing_errors++;
					$display("trigger word at cycle %0d too late for pulse ending at %0d",
						frame_start, end_cycle);
				end
			end
		end
		for (int i = 0; i < WORD_BITS; i++) begin
			check_flag("trg_active", active_bits[i], want_active);
		end
		// count is already up to date in the last bit of its word
		seen = revo_pkg::trg_count_t'(trg_words);
		check_count("trg_count", trg_count, seen);
		frames_seen++;
	endtask

	always @(negedge clock2) begin
		if (serial_frame) begin
			if (last_frame >= 0 && cycle - last_frame != WORD_BITS) begin
				timing_errors++;
				$display("serial_frame %0d cycles after the last one at cycle %0d, expected %0d",
					cycle - last_frame, cycle, WORD_BITS);
			end
			last_frame = cycle;
			frame_start = cycle;
			in_frame = 1'b1;
			bit_pos = 0;
		end
		if (in_frame) begin
			cur_word = {cur_word[WORD_BITS-2:0], serial_data};
			active_bits = {active_bits[WORD_BITS-2:0], trg_active};
			bit_pos++;
			if (bit_pos == WORD_BITS) begin
				finish_word();
				in_frame = 1'b0;
			end
		end else begin
			check_flag("trg_active", trg_active, 1'b0);
		end
	end

	// ------------------------------------------------------------
	// watchdog and main sequence
	// ------------------------------------------------------------

	initial begin : watchdog
		wait (table_ready);
		repeat (limit_cycles) @(posedge clock2);
		$display("timeout: the run did not finish within %0d cycles", limit_cycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin : stimulus
		revo_in = 1'b0;
		build_table();
		table_ready = 1'b1;

		@(posedge clock2);
		while (reset) @(posedge clock2);
		@(negedge clock2);
		check_flag("serial_data", serial_data, 1'b0);
		check_flag("serial_frame", serial_frame, 1'b0);
		check_flag("trg_active", trg_active, 1'b0);
		check_flag("word_ready", dut.word_ready, 1'b1);
		check_flag("trg_valid", dut.trg_valid, 1'b0);
		check_count("trg_count", trg_count, '0);

		// idle frames first
		while (frames_seen < 2) @(posedge clock2);
		@(negedge clock2);
		for (int i = 0; i < tab_width.size(); i++) begin
			apply_entry(i);
		end

		// drain and then wait two more frames for any stray trigger
		while (pending_end.size() != 0) @(posedge clock2);
		repeat (2 * WORD_BITS) @(negedge clock2);

		check_count("trigger words", revo_pkg::trg_count_t'(trg_words),
			revo_pkg::trg_count_t'(expected_total));
		check_count("final trg_count", trg_count, revo_pkg::trg_count_t'(expected_total));
		if (cycle - last_frame > WORD_BITS) begin
			timing_errors++;
			$display("serial stream stopped after cycle %0d", last_frame);
		end

		$display("errors: word %0d, count %0d, flag %0d, timing %0d",
			word_errors, count_errors, flag_errors, timing_errors);
		if (word_errors + count_errors + flag_errors + timing_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
